// File: apb_host_regs.sv
/* apb slave for the cpu side
   reads both register groups, keeps sticky strobe flags and readback bytes */

module apb_host_regs (
	input  logic                       fclk,
	input  logic                       reset,
	input  spi_avr_pkg::apb_req_t      req,
	output spi_avr_pkg::apb_rsp_t      rsp,
	input  spi_avr_pkg::input_event_t  events,
	input  spi_avr_pkg::system_ctrl_t  ctrl,
	output spi_avr_pkg::readback_t     readback,
	output logic [7:0]                 status_out
);

	import spi_avr_pkg::*;

	localparam int ADR_KBD_LAST = 4;  // 0..4, kbd bytes lsb first
	localparam int ADR_MUS      = 5;
	localparam int ADR_CFG0     = 6;
	localparam int ADR_WAIT_RD  = 7;
	localparam int ADR_FLAGS    = 8;
	localparam int ADR_WAIT_WR  = 9;
	localparam int ADR_GLU      = 10;
	localparam int ADR_COM      = 11;
	localparam int ADR_STATUS   = 12;

	readback_t rb_q;
	logic [7:0] status_q;
	logic [6:0] flags_q;
	logic [6:0] stb_now;
	logic access;
	logic rd;
	logic wr;
	logic rd_ok;
	logic wr_ok;

	assign access = req.psel & req.penable;
	assign rd     = access & ~req.pwrite;
	assign wr     = access & req.pwrite;
	assign rd_ok  = (req.paddr <= ADR_STATUS);
	assign wr_ok  = (req.paddr >= ADR_WAIT_WR) && (req.paddr <= ADR_STATUS);

	assign stb_now = {ctrl.wait_end, ctrl.genrst, events.kj_stb, events.mus_btnstb,
			events.mus_ystb, events.mus_xstb, events.kbd_stb};

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			rb_q     <= '0;
			status_q <= 8'h00;
			flags_q  <= 7'b0;
		end
		else
		begin
			if (wr)
			begin
				case (req.paddr)
					ADR_WAIT_WR: rb_q.wait_write    <= req.pwdata;
					ADR_GLU:     rb_q.gluclock_addr <= req.pwdata;
					ADR_COM:     rb_q.comport_addr  <= req.pwdata;
					ADR_STATUS:  status_q           <= req.pwdata;
					default:     ;
				endcase
			end
			// a strobe landing on the clearing read is kept
			if (rd && req.paddr == ADR_FLAGS)
				flags_q <= stb_now;
			else
				flags_q <= flags_q | stb_now;
		end
	end

	always_comb
	begin
		rsp.prdata = 8'h00;
		if (req.paddr <= ADR_KBD_LAST)
			rsp.prdata = events.kbd_out[req.paddr*8 +: 8];
		else
		begin
			case (req.paddr)
				ADR_MUS:     rsp.prdata = events.mus_out;
				ADR_CFG0:    rsp.prdata = ctrl.config0;
				ADR_WAIT_RD: rsp.prdata = ctrl.wait_read;
				ADR_FLAGS:   rsp.prdata = {1'b0, flags_q};
				ADR_WAIT_WR: rsp.prdata = rb_q.wait_write;
				ADR_GLU:     rsp.prdata = rb_q.gluclock_addr;
				ADR_COM:     rsp.prdata = rb_q.comport_addr;
				ADR_STATUS:  rsp.prdata = status_q;
				default:     rsp.prdata = 8'h00;
			endcase
		end
	end

	assign rsp.pready  = 1'b1; // zero wait states
	assign rsp.pslverr = access & (req.pwrite ? ~wr_ok : ~rd_ok);

	assign readback   = rb_q;
	assign status_out = status_q;

endmodule

// File: input_event_regs.sv
/* keyboard, mouse and joystick registers
   serial capture of the key matrix and mouse byte, with per-register strobes */

`include "spi_avr_defines.svh"

module input_event_regs (
	input  logic                       fclk,
	input  logic                       reset,
	input  spi_avr_pkg::spi_bit_t      bits,
	output spi_avr_pkg::input_event_t  events
);

	import spi_avr_pkg::*;

	logic sel_kbd;
	logic sel_mus;
	logic [4:0] stb_sel;
	logic [4:0] stb_q;  // kj, btn, y, x, kbd
	kbd_t kbd_held;
	logic [7:0] mus_held;

	assign sel_kbd = (bits.regnum == `REG_KBD);
	assign sel_mus = (bits.regnum[7:2] == `REG_MUS_X >> 2); // all four of 0x20..0x23

	assign stb_sel = {bits.regnum == `REG_KJ,
			bits.regnum == `REG_MUS_BTN,
			bits.regnum == `REG_MUS_Y,
			bits.regnum == `REG_MUS_X,
			bits.regnum == `REG_KBD_STB};

	shift_capture #(.T(kbd_t)) i_kbd (
		.fclk    (fclk),
		.reset   (reset),
		.sample  (bits.bit_stb & sel_kbd),
		.bit_in  (bits.data),
		.commit  (bits.frame_end & sel_kbd),
		.shift_q (),
		.held_q  (kbd_held)
	);

	shift_capture i_mus (
		.fclk    (fclk),
		.reset   (reset),
		.sample  (bits.bit_stb & sel_mus),
		.bit_in  (bits.data),
		.commit  (bits.frame_end & sel_mus),
		.shift_q (),
		.held_q  (mus_held)
	);

	// strobes line up with the committed values
	always_ff @(posedge fclk)
	begin
		if (reset)
			stb_q <= 5'b0;
		else
			stb_q <= {5{bits.frame_end}} & stb_sel;
	end

	assign events.kbd_out    = kbd_held;
	assign events.kbd_stb    = stb_q[0];
	assign events.mus_out    = mus_held;
	assign events.mus_xstb   = stb_q[1];
	assign events.mus_ystb   = stb_q[2];
	assign events.mus_btnstb = stb_q[3];
	assign events.kj_stb     = stb_q[4];

endmodule

// File: project.f
+incdir+.
spi_avr_pkg.sv
shift_capture.sv
spi_link.sv
input_event_regs.sv
system_ctrl_regs.sv
apb_host_regs.sv
spi_avr_top.sv
spi_avr_assert.sv
tb_spi_avr.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spi avr bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_spi_avr -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1

// File: shift_capture.sv
/* lsb-first serial capture register
   bits enter at the msb, a held copy is taken when the frame ends */

module shift_capture #(
	parameter type T = logic [7:0],
	parameter T RESET_VAL = T'(0)
) (
	input  logic fclk,
	input  logic reset,
	input  logic sample,
	input  logic bit_in,
	input  logic commit,
	output T     shift_q,
	output T     held_q
);

	localparam int W = $bits(T);

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			shift_q <= RESET_VAL;
			held_q  <= RESET_VAL;
		end
		else
		begin
			if (sample)
				shift_q <= T'({bit_in, shift_q[W-1:1]}); // older bits move toward lsb
			if (commit)
				held_q <= shift_q;
		end
	end

endmodule

// File: spi_avr_assert.sv
/* spi avr bridge assertions
   strobe width and source, config0 timing, miso reload and apb ready */

module spi_avr_assert (
	input logic                       fclk,
	input logic                       reset,
	input logic                       spics_n,
	input logic                       miso,
	input logic [7:0]                 status,
	input spi_avr_pkg::spi_bit_t      bits,
	input spi_avr_pkg::apb_req_t      apb_req,
	input spi_avr_pkg::apb_rsp_t      apb_rsp,
	input spi_avr_pkg::input_event_t  events,
	input spi_avr_pkg::system_ctrl_t  ctrl
);

	logic [6:0] stb;
	logic bad_width = 1'b0;
	logic bad_source = 1'b0;
	logic bad_cfg = 1'b0;
	logic bad_miso = 1'b0;
	logic bad_ready = 1'b0;
	logic failed;

	assign stb = {ctrl.wait_end, ctrl.genrst, events.kj_stb, events.mus_btnstb,
			events.mus_ystb, events.mus_xstb, events.kbd_stb};

	assign failed = bad_width | bad_source | bad_cfg | bad_miso | bad_ready;

	a_strobe_width: assert property (@(posedge fclk) disable iff (reset)
		(stb & $past(stb)) == 7'b0)
	else
	begin
		bad_width = 1'b1;
		$error("strobe held longer than one cycle: %b", stb);
	end

	// cs pin rise, two sync stages and the edge cycle, then the strobe
	a_strobe_source: assert property (@(posedge fclk) disable iff (reset)
		(|stb) |-> ($past(spics_n, 3) && !$past(spics_n, 4)))
	else
	begin
		bad_source = 1'b1;
		$error("strobe %b without a preceding cs rise", stb);
	end

	a_cfg0_timing: assert property (@(posedge fclk) disable iff (reset)
		(ctrl.config0 != $past(ctrl.config0)) |->
			($past(spics_n, 3) && !$past(spics_n, 4)))
	else
	begin
		bad_cfg = 1'b1;
		$error("config0 changed outside the cycle after cs rise");
	end

	a_miso_status: assert property (@(posedge fclk) disable iff (reset)
		bits.frame_end |=> (miso == $past(status[0]))) // status reload on cs rise
	else
	begin
		bad_miso = 1'b1;
		$error("miso does not show status bit 0 after cs rise");
	end

	a_apb_ready: assert property (@(posedge fclk) disable iff (reset)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
	else
	begin
		bad_ready = 1'b1;
		$error("pready low in an apb access phase");
	end

endmodule

// File: spi_avr_defines.svh
/* spi avr bridge constants
   register numbers sent by the avr, bus widths and reset values */

`ifndef SPI_AVR_DEFINES_SVH
`define SPI_AVR_DEFINES_SVH

// keyboard group
`define REG_KBD      8'h10
`define REG_KBD_STB  8'h11

// mouse and joystick group
`define REG_MUS_X    8'h20
`define REG_MUS_Y    8'h21
`define REG_MUS_BTN  8'h22
`define REG_KJ       8'h23

`define REG_RST      8'h30 // reset request, rom page in bits 5:4

// wait data and readback addresses
`define REG_WAIT     8'h40
`define REG_GLU_ADR  8'h41
`define REG_COM_ADR  8'h42

`define REG_CFG0     8'h50

`define KBD_W        40 // full key matrix
`define APB_AW       4

`define CFG0_RESET   8'h00

`endif

// File: spi_avr_pkg.sv
/* shared types of the spi avr bridge
   spi bit events, register group outputs and the apb request/response */

`include "spi_avr_defines.svh"

package spi_avr_pkg;

	typedef logic [`KBD_W-1:0] kbd_t;

	// one decoded spi event per fclk cycle
	typedef struct packed {
		logic [7:0] regnum;    // register number of the current frame
		logic       data;      // synchronized mosi
		logic       bit_stb;   // data-phase sck rise
		logic       frame_end; // cs rising edge
	} spi_bit_t;

	typedef struct packed {
		kbd_t       kbd_out;
		logic       kbd_stb;
		logic [7:0] mus_out;
		logic       mus_xstb;
		logic       mus_ystb;
		logic       mus_btnstb;
		logic       kj_stb;
	} input_event_t;

	typedef struct packed {
		logic [7:0] config0;
		logic       genrst;  // z80 reset pulse
		logic [1:0] rstrom;  // rom page after reset
		logic [7:0] wait_read;
		logic       wait_end;
	} system_ctrl_t;

	// bytes the cpu leaves for the avr to read back
	typedef struct packed {
		logic [7:0] wait_write;
		logic [7:0] gluclock_addr;
		logic [7:0] comport_addr;
	} readback_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [`APB_AW-1:0] paddr;
		logic [7:0]        pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
		logic       pslverr;
	} apb_rsp_t;

endpackage

// File: spi_avr_top.sv
/* spi avr bridge top level
   spi link, both register groups and the cpu apb port */

module spi_avr_top (
	input  logic                       fclk,
	input  logic                       reset,
	input  logic                       spics_n,
	input  logic                       sck,
	input  logic                       mosi,
	output logic                       miso,
	input  spi_avr_pkg::apb_req_t      apb_req,
	output spi_avr_pkg::apb_rsp_t      apb_rsp,
	output spi_avr_pkg::input_event_t  events,
	output spi_avr_pkg::system_ctrl_t  ctrl
);

	import spi_avr_pkg::*;

	spi_bit_t   bits;
	readback_t  readback;
	logic [7:0] status;   // shown to the avr during each register number byte

	spi_link i_link (
		.fclk      (fclk),
		.reset     (reset),
		.spics_n   (spics_n),
		.sck       (sck),
		.mosi      (mosi),
		.miso      (miso),
		.status_in (status),
		.readback  (readback),
		.bits      (bits)
	);

	input_event_regs i_input (
		.fclk   (fclk),
		.reset  (reset),
		.bits   (bits),
		.events (events)
	);

	system_ctrl_regs i_sysctl (
		.fclk  (fclk),
		.reset (reset),
		.bits  (bits),
		.ctrl  (ctrl)
	);

	apb_host_regs i_apb (
		.fclk       (fclk),
		.reset      (reset),
		.req        (apb_req),
		.rsp        (apb_rsp),
		.events     (events),
		.ctrl       (ctrl),
		.readback   (readback),
		.status_out (status)
	);

endmodule

// File: spi_link.sv
/* spi mode 0 slave front end
   synchronizes the pins, captures the register number and drives miso */

`include "spi_avr_defines.svh"

module spi_link (
	input  logic                    fclk,
	input  logic                    reset,
	input  logic                    spics_n,
	input  logic                    sck,
	input  logic                    mosi,
	output logic                    miso,
	input  logic [7:0]              status_in,
	input  spi_avr_pkg::readback_t  readback,
	output spi_avr_pkg::spi_bit_t   bits
);

	logic [2:0] cs_sync;   // two sync stages plus one for edge detection
	logic [2:0] sck_sync;
	logic [1:0] mosi_sync;
	logic       cs_hi;
	logic       cs_rise;
	logic       cs_fall;
	logic       sck_rise;
	logic [7:0] regnum;
	logic [7:0] shift_out;
	logic [7:0] data_sel;

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cs_sync  <= 3'b111; // idle, no edge after reset
			sck_sync <= 3'b000;
		end
		else
		begin
			cs_sync  <= {cs_sync[1:0], spics_n};
			sck_sync <= {sck_sync[1:0], sck};
		end
	end

	always_ff @(posedge fclk)
		mosi_sync <= {mosi_sync[0], mosi};

	assign cs_hi    = cs_sync[1];
	assign cs_rise  = ~cs_sync[2] & cs_sync[1];
	assign cs_fall  = cs_sync[2] & ~cs_sync[1];
	assign sck_rise = ~sck_sync[2] & sck_sync[1];

	// register number, shifted in while cs is high
	always_ff @(posedge fclk)
	begin
		if (reset || cs_rise)
			regnum <= 8'h00;
		else if (cs_hi && sck_rise)
			regnum <= {mosi_sync[1], regnum[7:1]};
	end

	always_comb
	begin
		case (regnum)
			`REG_WAIT:    data_sel = readback.wait_write;
			`REG_GLU_ADR: data_sel = readback.gluclock_addr;
			`REG_COM_ADR: data_sel = readback.comport_addr;
			default:      data_sel = 8'hFF;
		endcase
	end

	// status goes out with the register number, readback with the data
	always_ff @(posedge fclk)
	begin
		if (reset)
			shift_out <= 8'hFF;
		else if (cs_rise || cs_fall)
			shift_out <= cs_hi ? status_in : data_sel;
		else if (sck_rise)
			shift_out <= {1'b0, shift_out[7:1]};
	end

	assign miso = shift_out[0];

	assign bits.regnum    = regnum;
	assign bits.data      = mosi_sync[1];
	assign bits.bit_stb   = ~cs_hi & sck_rise;
	assign bits.frame_end = cs_rise; // regnum still valid in this cycle

endmodule

// File: system_ctrl_regs.sv
/* system control registers
   reset request with rom page, config0 and the wait data byte */

`include "spi_avr_defines.svh"

module system_ctrl_regs (
	input  logic                       fclk,
	input  logic                       reset,
	input  spi_avr_pkg::spi_bit_t      bits,
	output spi_avr_pkg::system_ctrl_t  ctrl
);

	logic sel_rst;
	logic sel_wait;
	logic sel_cfg;
	logic [7:0] rst_held;
	logic [7:0] cfg_held;
	logic [7:0] wait_shift;
	logic genrst_q;
	logic wait_end_q;

	assign sel_rst  = (bits.regnum == `REG_RST);
	assign sel_wait = (bits.regnum == `REG_WAIT);
	assign sel_cfg  = (bits.regnum == `REG_CFG0);

	shift_capture #(.RESET_VAL(`CFG0_RESET)) i_cfg0 (
		.fclk    (fclk),
		.reset   (reset),
		.sample  (bits.bit_stb & sel_cfg),
		.bit_in  (bits.data),
		.commit  (bits.frame_end & sel_cfg), // config only moves on cs rise
		.shift_q (),
		.held_q  (cfg_held)
	);

	shift_capture i_rst (
		.fclk    (fclk),
		.reset   (reset),
		.sample  (bits.bit_stb & sel_rst),
		.bit_in  (bits.data),
		.commit  (bits.frame_end & sel_rst),
		.shift_q (),
		.held_q  (rst_held)
	);

	// wait byte is read live by the cpu
	shift_capture i_wait (
		.fclk    (fclk),
		.reset   (reset),
		.sample  (bits.bit_stb & sel_wait),
		.bit_in  (bits.data),
		.commit  (1'b0),
		.shift_q (wait_shift),
		.held_q  ()
	);

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			genrst_q   <= 1'b0;
			wait_end_q <= 1'b0;
		end
		else
		begin
			genrst_q   <= bits.frame_end & sel_rst;
			wait_end_q <= bits.frame_end & sel_wait;
		end
	end

	assign ctrl.config0   = cfg_held;
	assign ctrl.genrst    = genrst_q;
	assign ctrl.rstrom    = rst_held[5:4];
	assign ctrl.wait_read = wait_shift;
	assign ctrl.wait_end  = wait_end_q;

endmodule

// File: tb_spi_avr.sv
/* testbench for the spi avr bridge
   bit-bangs spi frames as the avr and checks the cpu view over apb */

`include "spi_avr_defines.svh"

module tb_spi_avr;

	import spi_avr_pkg::*;

	localparam int HALF = 6;          // sck half period in fclk cycles
	localparam int MAX_CYCLES = 4000; // full sequence takes about 2800 cycles

	logic fclk = 1'b0;
	logic reset;
	logic spics_n;
	logic sck;
	logic mosi;
	logic miso;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	input_event_t events;
	system_ctrl_t ctrl;

	logic [31:0] rng = 32'h9838;
	int cycles = 0;
	int stb_cnt[7];   // kbd, x, y, btn, kj, genrst, wait_end
	int exp_cnt[7];
	logic [6:0] stb_vec;
	string stb_name[7] = '{"kbd_stb", "mus_xstb", "mus_ystb", "mus_btnstb",
			"kj_stb", "genrst", "wait_end"};

	spi_avr_top i_dut (
		.fclk    (fclk),
		.reset   (reset),
		.spics_n (spics_n),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.events  (events),
		.ctrl    (ctrl)
	);

	bind spi_avr_top spi_avr_assert i_assert (
		.fclk    (fclk),
		.reset   (reset),
		.spics_n (spics_n),
		.miso    (miso),
		.status  (status),
		.bits    (bits),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.events  (events),
		.ctrl    (ctrl)
	);

	always #10 fclk = ~fclk;

	assign stb_vec = {ctrl.wait_end, ctrl.genrst, events.kj_stb, events.mus_btnstb,
			events.mus_ystb, events.mus_xstb, events.kbd_stb};

	always @(negedge fclk)
	begin
		if (!reset)
			for (int i = 0; i < 7; i++)
				stb_cnt[i] += int'(stb_vec[i]); // one count per pulse
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(negedge fclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			abort_run("timeout, the test sequence did not finish");
		else if (i_dut.i_assert.failed)
			abort_run("a bound assertion failed");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng = xorshift(rng);
		return rng[7:0];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s: got %0h expected %0h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_strobes();
		for (int i = 0; i < 7; i++)
			check_value(stb_name[i], 64'(stb_cnt[i]), 64'(exp_cnt[i]));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge fclk);
	endtask

	// register number byte with cs high, then cs drops
	task automatic spi_header(input logic [7:0] regnum, output logic [7:0] seen);
		for (int i = 0; i < 8; i++)
		begin
			mosi = regnum[i];
			wait_cycles(HALF);
			seen[i] = miso; // sampled just before the rising sck
			sck = 1'b1;
			wait_cycles(HALF);
			sck = 1'b0;
		end
		wait_cycles(HALF);
		spics_n = 1'b0;
		wait_cycles(HALF);
	endtask

	task automatic spi_data(input logic [39:0] data, input int nbits,
			output logic [7:0] seen);
		seen = 8'h00;
		for (int i = 0; i < nbits; i++)
		begin
			mosi = data[i];
			wait_cycles(HALF);
			if (i < 8)
				seen[i] = miso;
			sck = 1'b1;
			wait_cycles(HALF);
			sck = 1'b0;
		end
	endtask

	task automatic spi_close();
		wait_cycles(HALF);
		spics_n = 1'b1;
		wait_cycles(HALF); // strobe has come and gone
	endtask

	task automatic spi_frame(input logic [7:0] regnum, input logic [39:0] data,
			input int nbits, output logic [7:0] st, output logic [7:0] dat);
		spi_header(regnum, st);
		spi_data(data, nbits, dat);
		spi_close();
	endtask

	task automatic apb_access(input logic write, input logic [3:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge fclk);
		apb_req.penable = 1'b1;
		#1;
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge fclk);
		apb_req = '0;
	endtask

	task automatic apb_expect_read(input logic [3:0] addr, input logic [7:0] exp,
			input string name);
		logic [7:0] rd;
		logic err;
		apb_access(1'b0, addr, 8'h00, rd, err);
		check_value(name, 64'(rd), 64'(exp));
		check_value({name, " pslverr"}, 64'(err), 64'd0);
	endtask

	task automatic apb_expect_write(input logic [3:0] addr, input logic [7:0] data);
		logic [7:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		check_value("write pslverr", 64'(err), 64'd0);
	endtask

	initial
	begin
		logic [39:0] kbd_val;
		logic [7:0] byte_val;
		logic [7:0] status_val;
		logic [7:0] wwr_val;
		logic [7:0] glu_val;
		logic [7:0] com_val;
		logic [7:0] st;
		logic [7:0] dat;
		logic [7:0] rd;
		logic err;

		reset   = 1'b1;
		spics_n = 1'b1;
		sck     = 1'b0;
		mosi    = 1'b0;
		apb_req = '0;
		wait_cycles(2);
		reset = 1'b0;
		wait_cycles(1);

		// state after reset
		check_value("strobes", 64'(stb_vec), 64'd0);
		check_value("config0", 64'(ctrl.config0), 64'(`CFG0_RESET));
		check_value("rstrom", 64'(ctrl.rstrom), 64'd0);
		check_value("spidi", 64'(miso), 64'd1);
		apb_expect_read(4'd6, 8'h00, "config0 read");

		// keyboard matrix, committed by the strobe frame
		kbd_val = {rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte()};
		spi_frame(`REG_KBD, kbd_val, 40, st, dat);
		check_strobes();
		spi_frame(`REG_KBD_STB, 40'h0, 0, st, dat);
		exp_cnt[0]++;
		check_strobes();
		check_value("kbd_out", 64'(events.kbd_out), 64'(kbd_val));
		for (int i = 0; i < 5; i++)
			apb_expect_read(4'(i), kbd_val[i*8 +: 8], "kbd byte");
		apb_expect_read(4'd8, 8'h01, "flags after kbd");

		// mouse x, y, buttons and joystick
		for (int i = 0; i < 4; i++)
		begin
			byte_val = rand_byte();
			spi_frame(8'(`REG_MUS_X + i), {32'h0, byte_val}, 8, st, dat);
			exp_cnt[i+1]++;
			check_strobes();
			check_value("mus_out", 64'(events.mus_out), 64'(byte_val));
			apb_expect_read(4'd5, byte_val, "mouse byte");
			apb_expect_read(4'd8, 8'(8'h01 << (i + 1)), "sticky flags");
		end
		apb_expect_read(4'd8, 8'h00, "cleared flags");

		// reset request, rom page 2
		spi_frame(`REG_RST, 40'h20, 8, st, dat);
		exp_cnt[5]++;
		check_strobes();
		check_value("rstrom", 64'(ctrl.rstrom), 64'd2);

		byte_val = rand_byte() | 8'h80; // never the reset value
		spi_header(`REG_CFG0, st);
		spi_data({32'h0, byte_val}, 8, dat);
		check_value("config0 before cs rise", 64'(ctrl.config0), 64'(`CFG0_RESET));
		spi_close();
		check_value("config0", 64'(ctrl.config0), 64'(byte_val));
		apb_expect_read(4'd6, byte_val, "config0 read");

		// status and readback bytes seen on miso
		status_val = rand_byte();
		wwr_val    = rand_byte();
		glu_val    = rand_byte();
		com_val    = rand_byte();
		apb_expect_write(4'd12, status_val);
		apb_expect_write(4'd9, wwr_val);
		apb_expect_write(4'd10, glu_val);
		apb_expect_write(4'd11, com_val);
		apb_expect_read(4'd12, status_val, "status_in read");
		spi_frame(`REG_GLU_ADR, {32'h0, rand_byte()}, 8, st, dat);
		check_value("miso gluclock_addr", 64'(dat), 64'(glu_val));

		byte_val = rand_byte();
		spi_frame(`REG_WAIT, {32'h0, byte_val}, 8, st, dat);
		exp_cnt[6]++;
		check_strobes();
		check_value("miso status", 64'(st), 64'(status_val));
		check_value("miso wait_write", 64'(dat), 64'(wwr_val));
		check_value("wait_read", 64'(ctrl.wait_read), 64'(byte_val));
		apb_expect_read(4'd7, byte_val, "wait_read read");

		spi_frame(`REG_COM_ADR, 40'h0, 8, st, dat);
		check_value("miso comport_addr", 64'(dat), 64'(com_val));
		check_value("miso status", 64'(st), 64'(status_val));

		// unmapped address
		apb_access(1'b0, 4'd15, 8'h00, rd, err);
		check_value("pslverr read 15", 64'(err), 64'd1);
		apb_access(1'b1, 4'd15, 8'h5A, rd, err);
		check_value("pslverr write 15", 64'(err), 64'd1);

		wait_cycles(2);
		if (i_dut.i_assert.failed)
			abort_run("a bound assertion failed");
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule
